// File: Makefile
VERILATOR ?= verilator
TOP       ?= stcDemodTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/adcFrontEnd.sv
`timescale 1ns/1ns
`include "stcDemod_cfg.svh"

module adcFrontEnd import stcDemodPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic [`ADC_W-1:0]   adc0,
    input  logic                adc0Overflow,
    input  logic                overflowClear,
    output sample_t             adcSample,
    output logic                overflowSticky
);

    logic [`ADC_W-1:0] adcReg;     // Pad capture

    // Offset binary to left-justified two's complement
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            adcReg    <= '0;
            adcSample <= '0;
        end else begin
            adcReg    <= adc0;
            adcSample <= {~adcReg[`ADC_W-1], adcReg[`ADC_W-2:0],
                          {(`SAMPLE_W-`ADC_W){1'b0}}};
        end
    end

    // Overflow wins over a clear in the same cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            overflowSticky <= 1'b0;
        end else if (adc0Overflow) begin
            overflowSticky <= 1'b1;
        end else if (overflowClear) begin
            overflowSticky <= 1'b0;
        end
    end

    sampleKnown: assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown(adcSample));

endmodule

// File: hdl/dacChannel.sv
`timescale 1ns/1ns
`include "stcDemod_cfg.svh"

module dacChannel import stcDemodPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    hostBusIf.peer  bus,
    input  sample_t demodData,
    input  sample_t stcData,
    input  sample_t adcSample,
    input  logic    demodClkEn,
    input  logic    stcClkEn,
    output dacCode_t dacData,
    output logic    dacClkEn
);

    dacSource_t source;
    busWord_t   wrWord;
    sample_t    selData;
    logic       selClkEn;

    assign wrWord = bus.wrData;

    //************************************************************
    // Source register
    //************************************************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            source <= '0;           // Loopback
        end else if (bus.cs && bus.addr[`SPACE_LSB-1:0] == `REG_DAC_SOURCE
                     && bus.wrEn[0]) begin
            source <= wrWord.lanes[0][3:0];
        end
    end

    assign bus.rdData = (bus.addr[`SPACE_LSB-1:0] == `REG_DAC_SOURCE)
                        ? {{(`DATA_W-4){1'b0}}, source} : '0;

    //************************************************************
    // Stream select, then DAC format
    //************************************************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            selData  <= '0;
            selClkEn <= 1'b0;
        end else begin
            case (source)
                `DAC_SRC_DEMOD: begin
                    selData  <= demodData;
                    selClkEn <= demodClkEn;
                end
                `DAC_SRC_STC: begin
                    selData  <= stcData;
                    selClkEn <= stcClkEn;
                end
                default: begin
                    selData  <= adcSample;  // ADC runs every clock
                    selClkEn <= 1'b1;
                end
            endcase
        end
    end

    // Top 13 magnitude bits below an inverted sign
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dacData  <= '0;
            dacClkEn <= 1'b0;
        end else begin
            dacData  <= {~selData[`SAMPLE_W-1], selData[`SAMPLE_W-2 -: `DAC_W-1]};
            dacClkEn <= selClkEn;
        end
    end

    // Pipeline stays quiet right after reset release
    quietAfterReset: assert property (@(posedge clk) $rose(arstN) |=> !dacClkEn);

endmodule

// File: hdl/hostBusIf.sv
`timescale 1ns/1ns
`include "stcDemod_cfg.svh"

// One segment of the host register bus
interface hostBusIf;

    logic                       cs;
    logic [`DATA_W/8-1:0]       wrEn;       // Per byte lane
    logic [`ADDR_W-1:0]         addr;
    logic [`DATA_W-1:0]         wrData;     // Same layout as busWord_t
    logic [`DATA_W-1:0]         rdData;

    modport decoder (
        output cs, wrEn, addr, wrData,
        input  rdData
    );

    modport peer (
        input  cs, wrEn, addr, wrData,
        output rdData
    );

endinterface

// File: hdl/regSpaceDecode.sv
`timescale 1ns/1ns
`include "stcDemod_cfg.svh"

module regSpaceDecode import stcDemodPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    hostBusIf.peer      host,
    hostBusIf.decoder   topBus,
    hostBusIf.decoder   dac0Bus,
    hostBusIf.decoder   dac1Bus
);

    localparam logic [`ADDR_W-1:0] topBase  = `TOP_SPACE;
    localparam logic [`ADDR_W-1:0] dac0Base = `DAC0_SPACE;
    localparam logic [`ADDR_W-1:0] dac1Base = `DAC1_SPACE;

    logic               hitTop;
    logic               hitDac0;
    logic               hitDac1;
    logic [`ADDR_W-1:0] offset;
    busWord_t           rdMux;

    // Space match on the upper address bits
    assign hitTop  = host.addr[`ADDR_W-1:`SPACE_LSB] == topBase[`ADDR_W-1:`SPACE_LSB];
    assign hitDac0 = host.addr[`ADDR_W-1:`SPACE_LSB] == dac0Base[`ADDR_W-1:`SPACE_LSB];
    assign hitDac1 = host.addr[`ADDR_W-1:`SPACE_LSB] == dac1Base[`ADDR_W-1:`SPACE_LSB];

    assign offset = {{(`ADDR_W-`SPACE_LSB){1'b0}}, host.addr[`SPACE_LSB-1:0]};

    assign topBus.cs    = host.cs && hitTop;
    assign topBus.wrEn  = topBus.cs ? host.wrEn : '0;
    assign topBus.addr  = offset;
    assign topBus.wrData = host.wrData;

    assign dac0Bus.cs   = host.cs && hitDac0;
    assign dac0Bus.wrEn = dac0Bus.cs ? host.wrEn : '0;
    assign dac0Bus.addr = offset;
    assign dac0Bus.wrData = host.wrData;

    assign dac1Bus.cs   = host.cs && hitDac1;
    assign dac1Bus.wrEn = dac1Bus.cs ? host.wrEn : '0;
    assign dac1Bus.addr = offset;
    assign dac1Bus.wrData = host.wrData;

    // Read-back mux gives zero when idle or unmapped
    always_comb begin
        rdMux = '0;
        if (topBus.cs) rdMux.word = topBus.rdData;
        if (dac0Bus.cs) rdMux.word = dac0Bus.rdData;
        if (dac1Bus.cs) rdMux.word = dac1Bus.rdData;
    end
    assign host.rdData = rdMux.word;

    // Spaces must never overlap
    onePeerSelected: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0({topBus.cs, dac0Bus.cs, dac1Bus.cs}));

endmodule

// File: hdl/stcDemodPkg.sv
`include "stcDemod_cfg.svh"

package stcDemodPkg;

    //************************************************************
    // Bus word
    //************************************************************

    // Whole word on reads and byte lanes on merged writes
    typedef union packed {
        logic [`DATA_W-1:0]             word;
        logic [`DATA_W/8-1:0][7:0]      lanes;
    } busWord_t;

    //************************************************************
    // Sample path types
    //************************************************************

    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // Offset binary with the MSB set at mid scale
    typedef logic [`DAC_W-1:0] dacCode_t;

    typedef logic [3:0] dacSource_t;

endpackage

// File: hdl/stcDemodTop.sv
`timescale 1ns/1ns
`include "stcDemod_cfg.svh"

module stcDemodTop import stcDemodPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,

    // Host register bus
    input  logic                    busCs,
    input  logic [`DATA_W/8-1:0]    busWrEn,
    input  logic [`ADDR_W-1:0]      busAddr,
    input  logic [`DATA_W-1:0]      busDataIn,
    output logic [`DATA_W-1:0]      busDataOut,

    // ADC
    input  logic [`ADC_W-1:0]       adc0,
    input  logic                    adc0Overflow,

    // Demodulator and STC streams
    input  sample_t                 demodDac0Data,
    input  sample_t                 demodDac1Data,
    input  logic                    demodDac0ClkEn,
    input  logic                    demodDac1ClkEn,
    input  sample_t                 stcDac0Data,
    input  sample_t                 stcDac1Data,
    input  logic                    stcDac0ClkEn,
    input  logic                    stcDac1ClkEn,

    // DACs
    output dacCode_t                dac0Data,
    output dacCode_t                dac1Data,
    output logic                    dac0ClkEn,
    output logic                    dac1ClkEn
);

    sample_t adcSample;
    logic    overflowSticky;
    logic    overflowClear;

    //************************************************************
    // Register bus
    //************************************************************
    hostBusIf hostBus ();
    hostBusIf topBus ();
    hostBusIf dac0Bus ();
    hostBusIf dac1Bus ();

    assign hostBus.cs     = busCs;
    assign hostBus.wrEn   = busWrEn;
    assign hostBus.addr   = busAddr;
    assign hostBus.wrData = busDataIn;
    assign busDataOut     = hostBus.rdData;

    regSpaceDecode u_decode (.clk(clk), .arstN(arstN), .host(hostBus),
        .topBus(topBus), .dac0Bus(dac0Bus), .dac1Bus(dac1Bus));

    topRegs u_topRegs (.clk(clk), .arstN(arstN), .bus(topBus),
        .overflowSticky(overflowSticky), .overflowClear(overflowClear));

    //************************************************************
    // Sample path
    //************************************************************
    adcFrontEnd u_adc (.clk(clk), .arstN(arstN), .adc0(adc0),
        .adc0Overflow(adc0Overflow), .overflowClear(overflowClear),
        .adcSample(adcSample), .overflowSticky(overflowSticky));

    dacChannel u_dac0 (.clk(clk), .arstN(arstN), .bus(dac0Bus),
        .demodData(demodDac0Data), .stcData(stcDac0Data), .adcSample(adcSample),
        .demodClkEn(demodDac0ClkEn), .stcClkEn(stcDac0ClkEn),
        .dacData(dac0Data), .dacClkEn(dac0ClkEn));

    dacChannel u_dac1 (.clk(clk), .arstN(arstN), .bus(dac1Bus),
        .demodData(demodDac1Data), .stcData(stcDac1Data), .adcSample(adcSample),
        .demodClkEn(demodDac1ClkEn), .stcClkEn(stcDac1ClkEn),
        .dacData(dac1Data), .dacClkEn(dac1ClkEn));

endmodule

// File: hdl/stcDemod_cfg.svh
`ifndef STCDEMOD_CFG_SVH
`define STCDEMOD_CFG_SVH

// Bus geometry
`define ADDR_W          13
`define DATA_W          32
`define SPACE_LSB       4       // Spaces are 16 bytes wide

// Sample and converter widths
`define SAMPLE_W        18
`define ADC_W           14
`define DAC_W           14

// Address space bases
`define TOP_SPACE       13'h000
`define DAC0_SPACE      13'h100
`define DAC1_SPACE      13'h110

// Register offsets within a space
`define REG_VERSION     4'h0
`define REG_SCRATCH     4'h4
`define REG_STATUS      4'h8
`define REG_DAC_SOURCE  4'h0

// Any other DAC source code selects ADC loopback
`define DAC_SRC_DEMOD   4'd1
`define DAC_SRC_STC     4'd2

`define VER_NUMBER      16'd654
`define FPGA_TYPE       16'h7A16

`endif

// File: hdl/topRegs.sv
`timescale 1ns/1ns
`include "stcDemod_cfg.svh"

module topRegs import stcDemodPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    hostBusIf.peer  bus,
    input  logic    overflowSticky,
    output logic    overflowClear
);

    busWord_t scratch;
    busWord_t wrWord;
    busWord_t rdWord;

    assign wrWord = bus.wrData;

    //************************************************************
    // Scratch register merged by byte lane
    //************************************************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            scratch <= '0;
        end else if (bus.cs && bus.addr[`SPACE_LSB-1:0] == `REG_SCRATCH) begin
            for (int i = 0; i < `DATA_W/8; i++) begin
                if (bus.wrEn[i]) begin
                    scratch.lanes[i] <= wrWord.lanes[i];
                end
            end
        end
    end

    // Write one to status bit 0 clears the sticky flag
    assign overflowClear = bus.cs && bus.addr[`SPACE_LSB-1:0] == `REG_STATUS
                           && bus.wrEn[0] && wrWord.lanes[0][0];

    //************************************************************
    // Read back
    //************************************************************
    always_comb begin
        rdWord = '0;
        case (bus.addr[`SPACE_LSB-1:0])
            `REG_VERSION: rdWord.word = {`FPGA_TYPE, `VER_NUMBER};
            `REG_SCRATCH: rdWord.word = scratch.word;
            `REG_STATUS:  rdWord.word = {{(`DATA_W-1){1'b0}}, overflowSticky};
            default:      rdWord.word = '0;
        endcase
    end
    assign bus.rdData = rdWord.word;

    // Decoder gates strobes with the select
    noStrobeWithoutCs: assert property (@(posedge clk) disable iff (!arstN)
        !bus.cs |-> bus.wrEn == '0);

endmodule

// File: src.f
+incdir+hdl
hdl/stcDemodPkg.sv
hdl/hostBusIf.sv
hdl/regSpaceDecode.sv
hdl/topRegs.sv
hdl/adcFrontEnd.sv
hdl/dacChannel.sv
hdl/stcDemodTop.sv
testbench/stcDemodTb.sv

// File: testbench/stcDemodCases.txt
# op addr(hex) byteEn(hex) data(hex) name, all fields present on every line
# W write, R read (data is expected word), S a=dac0 src b=dac1 src c=count, P overflow pulse
R 000 0 7a16028e versionWord
R 004 0 00000000 scratchReset
R 008 0 00000000 statusReset
R 040 0 00000000 unmappedTop
R 120 0 00000000 unmappedHigh
R 100 0 00000000 dac0SrcReset
W 004 f 12345678 scratchFull
W 004 5 aabbccdd scratchLanes02
R 004 0 12bb56dd scratchMerged
W 004 8 ff000000 scratchLane3
R 004 0 ffbb56dd scratchTop
S 0 0 40 adcLoopback
W 100 1 00000001 dac0ToDemod
W 110 1 00000002 dac1ToStc
R 100 0 00000001 dac0SrcRead
R 110 0 00000002 dac1SrcRead
S 1 2 40 demodAndStc
W 100 1 00000007 dac0OtherCode
R 100 0 00000007 dac0OtherRead
S 7 2 20 otherCodeLoopback
P 0 0 0 overflowPulse
R 008 0 00000001 statusSet
W 008 1 00000001 statusClear
R 008 0 00000000 statusCleared

// File: testbench/stcDemodTb.sv
`timescale 1ns/1ns
`include "stcDemod_cfg.svh"

module stcDemodTb import stcDemodPkg::*; ();

    localparam int clkPeriod = 8;

    logic                   clk;
    logic                   arstN;
    logic                   busCs;
    logic [`DATA_W/8-1:0]   busWrEn;
    logic [`ADDR_W-1:0]     busAddr;
    logic [`DATA_W-1:0]     busDataIn;
    logic [`DATA_W-1:0]     busDataOut;
    logic [`ADC_W-1:0]      adc0;
    logic                   adc0Overflow;
    sample_t                demodDac0Data;
    sample_t                demodDac1Data;
    sample_t                stcDac0Data;
    sample_t                stcDac1Data;
    logic                   demodDac0ClkEn;
    logic                   demodDac1ClkEn;
    logic                   stcDac0ClkEn;
    logic                   stcDac1ClkEn;
    dacCode_t               dac0Data;
    dacCode_t               dac1Data;
    logic                   dac0ClkEn;
    logic                   dac1ClkEn;

    // Parsed case lines
    string       opQ[$];
    string       nameQ[$];
    logic [31:0] aQ[$];
    logic [31:0] bQ[$];
    logic [31:0] cQ[$];
    int          totalCycles = 0;
    bit          casesLoaded = 1'b0;
    int          checkCount = 0;
    int          mismatchCount = 0;
    int          failCount = 0;

    stcDemodTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    //************************************************************
    // Compare tasks
    //************************************************************
    task automatic checkWord(input string name, input busWord_t expected, input busWord_t actual);
        checkCount++;
        if (actual !== expected) begin
            mismatchCount++;
            $display("Mismatch %s: expected %08h, actual %08h", name, expected.word, actual.word);
        end
    endtask

    task automatic checkDac(input string name, input dacCode_t expected, input dacCode_t actual);
        checkCount++;
        if (actual !== expected) begin
            mismatchCount++;
            $display("Mismatch %s: expected %04h, actual %04h", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            mismatchCount++;
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic printCounts();
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checkCount, mismatchCount, failCount);
    endtask

    //************************************************************
    // Case file reader
    //************************************************************
    task automatic loadCases();
        int          fd;
        int          n;
        string       line;
        string       op;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("testbench/stcDemodCases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file testbench/stcDemodCases.txt");
            failCount++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") continue;   // Blank or column notes
            n = $sscanf(line, "%s %h %h %h %s", op, a, b, c, name);
            if (n != 5) begin
                $display("Case line could not be parsed: %s", line);
                failCount++;
                continue;
            end
            opQ.push_back(op);
            aQ.push_back(a);
            bQ.push_back(b);
            cQ.push_back(c);
            nameQ.push_back(name);
            totalCycles += (op == "S") ? int'(c) + 5 : 2;
        end
        $fclose(fd);
    endtask

    //************************************************************
    // Bus operations
    //************************************************************
    task automatic busWrite(input logic [31:0] addr, input logic [31:0] be,
                            input logic [31:0] data);
        @(posedge clk);
        busCs     <= 1'b1;
        busWrEn   <= be[`DATA_W/8-1:0];
        busAddr   <= addr[`ADDR_W-1:0];
        busDataIn <= data;
        @(posedge clk);                 // Write lands on this edge
        busCs     <= 1'b0;
        busWrEn   <= '0;
    endtask

    task automatic busRead(input logic [31:0] addr, input logic [31:0] expected,
                           input string name);
        @(posedge clk);
        busCs   <= 1'b1;
        busWrEn <= '0;
        busAddr <= addr[`ADDR_W-1:0];
        @(negedge clk);
        checkWord(name, expected, busDataOut);
        @(posedge clk);
        busCs   <= 1'b0;
    endtask

    task automatic pulseOverflow();
        @(posedge clk);
        adc0Overflow <= 1'b1;
        @(posedge clk);
        adc0Overflow <= 1'b0;
    endtask

    //************************************************************
    // DAC model
    //************************************************************
    // Inverted sign above sample bits 16 to 4
    function automatic dacCode_t toDacCode(input sample_t s);
        return {~s[`SAMPLE_W-1], s[`SAMPLE_W-2:`SAMPLE_W-`DAC_W]};
    endfunction

    function automatic int streamLatency(input dacSource_t src);
        if (src == `DAC_SRC_DEMOD || src == `DAC_SRC_STC) return 2;
        return 4;                       // Reclock adds two edges
    endfunction

    // Loopback returns the raw ADC code unchanged
    function automatic dacCode_t expectedCode(input dacSource_t src,
                                              input logic [`ADC_W-1:0] adcCode,
                                              input sample_t demod, input sample_t stc);
        if (src == `DAC_SRC_DEMOD) return toDacCode(demod);
        if (src == `DAC_SRC_STC) return toDacCode(stc);
        return adcCode;
    endfunction

    function automatic logic expectedEn(input dacSource_t src, input logic demodEn,
                                        input logic stcEn);
        if (src == `DAC_SRC_DEMOD) return demodEn;
        if (src == `DAC_SRC_STC) return stcEn;
        return 1'b1;
    endfunction

    task automatic runSamples(input dacSource_t src0, input dacSource_t src1,
                              input int count, input string name);
        dacCode_t    exp0[$];
        dacCode_t    exp1[$];
        logic        en0[$];
        logic        en1[$];
        logic [31:0] rnd[6];
        int          lat0;
        int          lat1;
        lat0 = streamLatency(src0);
        lat1 = streamLatency(src1);
        for (int i = 0; i < count + 4; i++) begin
            for (int k = 0; k < 6; k++) begin
                rnd[k] = $urandom();
            end
            @(posedge clk);
            adc0           <= rnd[0][`ADC_W-1:0];
            demodDac0Data  <= rnd[1][`SAMPLE_W-1:0];
            demodDac1Data  <= rnd[2][`SAMPLE_W-1:0];
            stcDac0Data    <= rnd[3][`SAMPLE_W-1:0];
            stcDac1Data    <= rnd[4][`SAMPLE_W-1:0];
            demodDac0ClkEn <= rnd[5][0];
            demodDac1ClkEn <= rnd[5][1];
            stcDac0ClkEn   <= rnd[5][2];
            stcDac1ClkEn   <= rnd[5][3];
            exp0.push_back(expectedCode(src0, rnd[0][`ADC_W-1:0], rnd[1][`SAMPLE_W-1:0],
                                        rnd[3][`SAMPLE_W-1:0]));
            exp1.push_back(expectedCode(src1, rnd[0][`ADC_W-1:0], rnd[2][`SAMPLE_W-1:0],
                                        rnd[4][`SAMPLE_W-1:0]));
            en0.push_back(expectedEn(src0, rnd[5][0], rnd[5][2]));
            en1.push_back(expectedEn(src1, rnd[5][1], rnd[5][3]));
            @(negedge clk);
            if (exp0.size() > lat0) begin
                checkDac(name, exp0.pop_front(), dac0Data);
                checkFlag(name, en0.pop_front(), dac0ClkEn);
            end
            if (exp1.size() > lat1) begin
                checkDac(name, exp1.pop_front(), dac1Data);
                checkFlag(name, en1.pop_front(), dac1ClkEn);
            end
        end
    endtask

    //************************************************************
    // Main sequence
    //************************************************************
    initial begin
        void'($urandom(64));
        arstN          = 1'b0;
        busCs          = 1'b0;
        busWrEn        = '0;
        busAddr        = '0;
        busDataIn      = '0;
        adc0           = '0;
        adc0Overflow   = 1'b0;
        demodDac0Data  = '0;
        demodDac1Data  = '0;
        stcDac0Data    = '0;
        stcDac1Data    = '0;
        demodDac0ClkEn = 1'b0;
        demodDac1ClkEn = 1'b0;
        stcDac0ClkEn   = 1'b0;
        stcDac1ClkEn   = 1'b0;
        loadCases();
        casesLoaded = 1'b1;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkFlag("resetDac0En", 1'b0, dac0ClkEn);
        checkFlag("resetDac1En", 1'b0, dac1ClkEn);
        for (int k = 0; k < opQ.size(); k++) begin
            if (opQ[k] == "W") busWrite(aQ[k], bQ[k], cQ[k]);
            else if (opQ[k] == "R") busRead(aQ[k], cQ[k], nameQ[k]);
            else if (opQ[k] == "S") runSamples(aQ[k][3:0], bQ[k][3:0], int'(cQ[k]), nameQ[k]);
            else if (opQ[k] == "P") pulseOverflow();
            else begin
                $display("Unknown operation %s in case %s", opQ[k], nameQ[k]);
                failCount++;
            end
        end
        repeat (2) @(posedge clk);
        printCounts();
        if (mismatchCount == 0 && failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the loaded cases
    initial begin
        wait (casesLoaded);
        #(clkPeriod * (totalCycles + 100));
        $display("Timeout: cases did not finish within %0d clock cycles", totalCycles + 100);
        failCount++;
        printCounts();
        $display("*** FAILED ***");
        $finish;
    end

endmodule
